//--- conv_filter_pkg.sv
package conv_filter_pkg;

	// one rgb pixel, red in the top byte
	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} pixel_t;

	// vertically aligned pixels of one padded column
	// top is two rows old, bot is the pixel of the current beat
	typedef struct packed {
		pixel_t top;
		pixel_t mid;
		pixel_t bot;
	} column_t;

	// position tag that rides beside the data
	typedef struct packed {
		// window centred on an image pixel
		logic valid;
		// last padded pixel of the frame
		logic done;
	} pos_tag_t;

	// window is fixed at 3x3
	localparam int KERNEL_SIZE = 3;

	// sharpen kernel
	// row 0 is the top row, column 0 is the oldest column
	localparam logic signed [7:0] KERNEL_COEFF [KERNEL_SIZE][KERNEL_SIZE] = '{
		'{ 8'sd0, -8'sd1,  8'sd0},
		'{-8'sd1,  8'sd5, -8'sd1},
		'{ 8'sd0, -8'sd1,  8'sd0}
	};

	// accepted beats from a column to its channel sum
	localparam int CONV_BEATS = 3;

	// signed channel sum, wide enough for 5*255 and for -4*255
	localparam int SUM_WIDTH = 16;

endpackage

//--- row_delay_line.sv
`timescale 1ns/1ps

module row_delay_line #(
	parameter int img_width = 320
) (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     i_enable,
	input  conv_filter_pkg::pixel_t  i_pixel,
	output conv_filter_pkg::column_t o_column
);

	import conv_filter_pkg::*;

	// one padded row per line
	localparam int ROW_LEN = img_width + 2;
	// lines needed for a 3 row window
	localparam int NUM_LINES = KERNEL_SIZE - 1;

	// line 0 delays the incoming pixel by one padded row
	// line 1 delays the output of line 0 by another row
	pixel_t line_mem [NUM_LINES][ROW_LEN];
	// pixel entering each line
	pixel_t line_in [NUM_LINES];

	assign line_in[0] = i_pixel;
	// lines are chained, the tail of one feeds the next
	assign line_in[1] = line_mem[0][ROW_LEN-1];

	// shift only on accepted beats
	// the lines hold while the filter sits in reset
	always_ff @(posedge clk) begin
		if (i_enable && !reset) begin
			for (int l = 0; l < NUM_LINES; l++) begin
				line_mem[l][0] <= line_in[l];
				for (int i = 1; i < ROW_LEN; i++) begin
					line_mem[l][i] <= line_mem[l][i-1];
				end
			end
		end
	end

	// current pixel goes straight to the bottom of the column
	assign o_column.bot = i_pixel;
	// tail of line 0 is exactly one padded row old
	assign o_column.mid = line_mem[0][ROW_LEN-1];
	// tail of line 1 is two padded rows old
	assign o_column.top = line_mem[1][ROW_LEN-1];

endmodule

//--- frame_position_tracker.sv
`timescale 1ns/1ps

module frame_position_tracker #(
	parameter int img_width  = 320,
	parameter int img_height = 240
) (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      i_enable,
	output conv_filter_pkg::pos_tag_t o_tag
);

	import conv_filter_pkg::*;

	// padded frame geometry
	localparam int ROW_LEN    = img_width + 2;
	localparam int FRAME_ROWS = img_height + 2;
	localparam int COL_W      = $clog2(ROW_LEN);
	localparam int ROW_W      = $clog2(FRAME_ROWS);

	// position of the column on the current beat
	logic [COL_W-1:0] col_cnt;
	logic [ROW_W-1:0] row_cnt;

	// end of padded row and end of padded frame
	logic last_col;
	logic last_row;

	assign last_col = (col_cnt == COL_W'(ROW_LEN - 1));
	assign last_row = (row_cnt == ROW_W'(FRAME_ROWS - 1));

	// counters advance once per accepted beat
	// both wrap at the frame end so the next frame needs no gap
	always_ff @(posedge clk) begin
		if (reset) begin
			col_cnt <= '0;
			row_cnt <= '0;
		end else if (i_enable) begin
			if (last_col) begin
				col_cnt <= '0;
				if (last_row) begin
					row_cnt <= '0;
				end else begin
					row_cnt <= row_cnt + 1'b1;
				end
			end else begin
				col_cnt <= col_cnt + 1'b1;
			end
		end
	end

	// window is complete once two earlier columns and two earlier rows exist
	// it is then centred on padded pixel (row-1, col-1)
	assign o_tag.valid = (col_cnt >= COL_W'(KERNEL_SIZE - 1)) &&
		(row_cnt >= ROW_W'(KERNEL_SIZE - 1));

	// last padded pixel of the frame
	assign o_tag.done = last_col && last_row;

endmodule

//--- channel_convolver.sv
`timescale 1ns/1ps

module channel_convolver (
	input  logic                                       clk,
	input  logic                                       reset,
	input  logic                                       i_enable,
	input  logic [7:0]                                 i_top,
	input  logic [7:0]                                 i_mid,
	input  logic [7:0]                                 i_bot,
	output logic signed [conv_filter_pkg::SUM_WIDTH-1:0] o_sum
);

	import conv_filter_pkg::*;

	// column of this channel on the current beat, row 0 at the top
	logic [7:0] cur_col [KERNEL_SIZE];
	// previous columns, index 0 is the newer one
	logic [7:0] col_hist [KERNEL_SIZE][KERNEL_SIZE-1];
	// full window, column 0 is the oldest
	logic [7:0] window [KERNEL_SIZE][KERNEL_SIZE];

	// beat 1, products
	logic signed [SUM_WIDTH-1:0] prod_q [KERNEL_SIZE][KERNEL_SIZE];
	// beat 2, one sum per kernel row
	logic signed [SUM_WIDTH-1:0] row_sum_d [KERNEL_SIZE];
	logic signed [SUM_WIDTH-1:0] row_sum_q [KERNEL_SIZE];
	// beat 3, channel sum
	logic signed [SUM_WIDTH-1:0] sum_d;
	logic signed [SUM_WIDTH-1:0] sum_q;

	assign cur_col[0] = i_top;
	assign cur_col[1] = i_mid;
	assign cur_col[2] = i_bot;

	// newest column comes straight from the row delay line
	// so the window is ready in the same beat as its last column
	always_comb begin
		for (int r = 0; r < KERNEL_SIZE; r++) begin
			window[r][KERNEL_SIZE-1] = cur_col[r];
			for (int c = 0; c < KERNEL_SIZE - 1; c++) begin
				window[r][c] = col_hist[r][KERNEL_SIZE-2-c];
			end
		end
	end

	// horizontal history, moves only on accepted beats
	always_ff @(posedge clk) begin
		if (i_enable) begin
			for (int r = 0; r < KERNEL_SIZE; r++) begin
				col_hist[r][0] <= cur_col[r];
				for (int j = 1; j < KERNEL_SIZE - 1; j++) begin
					col_hist[r][j] <= col_hist[r][j-1];
				end
			end
		end
	end

	// adder trees between the registered beats
	always_comb begin
		sum_d = '0;
		for (int r = 0; r < KERNEL_SIZE; r++) begin
			row_sum_d[r] = '0;
			for (int c = 0; c < KERNEL_SIZE; c++) begin
				row_sum_d[r] = row_sum_d[r] + prod_q[r][c];
			end
			sum_d = sum_d + row_sum_q[r];
		end
	end

	// three enabled stages, so several windows are in flight at once
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int r = 0; r < KERNEL_SIZE; r++) begin
				for (int c = 0; c < KERNEL_SIZE; c++) begin
					prod_q[r][c] <= '0;
				end
				row_sum_q[r] <= '0;
			end
			sum_q <= '0;
		end else if (i_enable) begin
			for (int r = 0; r < KERNEL_SIZE; r++) begin
				for (int c = 0; c < KERNEL_SIZE; c++) begin
					// pixel is unsigned, a zero msb keeps it positive
					prod_q[r][c] <= KERNEL_COEFF[r][c] * $signed({1'b0, window[r][c]});
				end
				row_sum_q[r] <= row_sum_d[r];
			end
			sum_q <= sum_d;
		end
	end

	assign o_sum = sum_q;

endmodule

//--- result_clamp.sv
`timescale 1ns/1ps

module result_clamp (
	input  logic                                       clk,
	input  logic                                       reset,
	input  logic                                       i_enable,
	input  conv_filter_pkg::pos_tag_t                  i_tag,
	input  logic signed [conv_filter_pkg::SUM_WIDTH-1:0] i_sum_r,
	input  logic signed [conv_filter_pkg::SUM_WIDTH-1:0] i_sum_g,
	input  logic signed [conv_filter_pkg::SUM_WIDTH-1:0] i_sum_b,
	output logic                                       o_valid,
	output logic                                       o_done,
	output conv_filter_pkg::pixel_t                    o_data
);

	import conv_filter_pkg::*;

	// tag delay to match the convolver depth
	pos_tag_t tag_pipe [CONV_BEATS];
	// output stage, tag and pixel move together
	pos_tag_t out_tag;
	pixel_t   out_pixel;

	// saturate a signed sum into 0..255
	function automatic logic [7:0] saturate(input logic signed [SUM_WIDTH-1:0] sum);
		logic [7:0] res;
		if (sum < 0) begin
			res = 8'd0;
		end else if (sum > 255) begin
			res = 8'd255;
		end else begin
			res = sum[7:0];
		end
		return res;
	endfunction

	// tag shift line and output tag
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < CONV_BEATS; i++) begin
				tag_pipe[i] <= '0;
			end
			out_tag <= '0;
		end else if (i_enable) begin
			tag_pipe[0] <= i_tag;
			for (int i = 1; i < CONV_BEATS; i++) begin
				tag_pipe[i] <= tag_pipe[i-1];
			end
			// sums are aligned with the tail of the tag line here
			out_tag <= tag_pipe[CONV_BEATS-1];
		end
	end

	// clamped pixel, same beat as out_tag
	always_ff @(posedge clk) begin
		if (i_enable) begin
			out_pixel.r <= saturate(i_sum_r);
			out_pixel.g <= saturate(i_sum_g);
			out_pixel.b <= saturate(i_sum_b);
		end
	end

	// strobes only show on accepted beats
	assign o_valid = out_tag.valid & i_enable;
	assign o_done  = out_tag.done & i_enable;
	assign o_data  = out_pixel;

endmodule

//--- conv_filter_top.sv
`timescale 1ns/1ps

module conv_filter_top #(
	parameter int img_width  = 320,
	parameter int img_height = 240
) (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    i_valid,
	input  conv_filter_pkg::pixel_t i_data,
	output logic                    o_valid,
	output logic                    o_done,
	output conv_filter_pkg::pixel_t o_data
);

	import conv_filter_pkg::*;

	// registered input, beat_valid enables every stage below
	logic   beat_valid;
	pixel_t beat_pixel;

	// column and its position tag for the current beat
	column_t  column;
	pos_tag_t tag;

	// per channel sums, CONV_BEATS beats behind the column
	logic signed [SUM_WIDTH-1:0] sum_r;
	logic signed [SUM_WIDTH-1:0] sum_g;
	logic signed [SUM_WIDTH-1:0] sum_b;

	// input register
	// the pixel is always captured, only valid decides whether it counts
	always_ff @(posedge clk) begin
		if (reset) begin
			beat_valid <= 1'b0;
		end else begin
			beat_valid <= i_valid;
		end
		beat_pixel <= i_data;
	end

	// vertical column from two row delays
	row_delay_line #(
		.img_width (img_width)
	) u_row_delay (
		.clk      (clk),
		.reset    (reset),
		.i_enable (beat_valid),
		.i_pixel  (beat_pixel),
		.o_column (column)
	);

	// decode, padded position to tag
	frame_position_tracker #(
		.img_width  (img_width),
		.img_height (img_height)
	) u_tracker (
		.clk      (clk),
		.reset    (reset),
		.i_enable (beat_valid),
		.o_tag    (tag)
	);

	// execute, one convolver per colour channel
	channel_convolver u_conv_r (
		.clk      (clk),
		.reset    (reset),
		.i_enable (beat_valid),
		.i_top    (column.top.r),
		.i_mid    (column.mid.r),
		.i_bot    (column.bot.r),
		.o_sum    (sum_r)
	);

	channel_convolver u_conv_g (
		.clk      (clk),
		.reset    (reset),
		.i_enable (beat_valid),
		.i_top    (column.top.g),
		.i_mid    (column.mid.g),
		.i_bot    (column.bot.g),
		.o_sum    (sum_g)
	);

	channel_convolver u_conv_b (
		.clk      (clk),
		.reset    (reset),
		.i_enable (beat_valid),
		.i_top    (column.top.b),
		.i_mid    (column.mid.b),
		.i_bot    (column.bot.b),
		.o_sum    (sum_b)
	);

	// result, clamp and realign the tag with the data
	result_clamp u_clamp (
		.clk      (clk),
		.reset    (reset),
		.i_enable (beat_valid),
		.i_tag    (tag),
		.i_sum_r  (sum_r),
		.i_sum_g  (sum_g),
		.i_sum_b  (sum_b),
		.o_valid  (o_valid),
		.o_done   (o_done),
		.o_data   (o_data)
	);

endmodule

//--- conv_filter_assertions.sv
`timescale 1ns/1ps

module conv_filter_assertions (
	input logic clk,
	input logic reset,
	input logic i_in_valid,
	input logic i_out_valid,
	input logic i_out_done
);

	// frame end flag rides on a valid pixel only
	done_needs_valid: assert property (
		@(posedge clk) disable iff (reset) i_out_done |-> i_out_valid
	) else $error("o_done high without o_valid");

	// pipeline only moves on beats taken by the input register on the previous edge
	valid_needs_beat: assert property (
		@(posedge clk) disable iff (reset) i_out_valid |-> $past(i_in_valid)
	) else $error("o_valid high in a cycle without an accepted beat");

	// first cycle after reset is quiet
	quiet_after_reset: assert property (
		@(posedge clk) $fell(reset) |-> (!i_out_valid && !i_out_done)
	) else $error("output strobes high in the first cycle after reset");

endmodule

bind conv_filter_top conv_filter_assertions u_assertions (
	.clk         (clk),
	.reset       (reset),
	.i_in_valid  (i_valid),
	.i_out_valid (o_valid),
	.i_out_done  (o_done)
);

//--- conv_filter_tb.sv
`timescale 1ns/1ps

module conv_filter_tb;

	import conv_filter_pkg::*;

	// small image keeps the data file readable
	localparam int IMG_W           = 8;
	localparam int IMG_H           = 6;
	localparam int IN_PIXELS       = (IMG_W + 2) * (IMG_H + 2);
	localparam int OUT_PIXELS      = IMG_W * IMG_H;
	localparam int TOTAL_WORDS     = IN_PIXELS + OUT_PIXELS;
	localparam int NUM_FRAMES      = 2;
	localparam int FLUSH_BEATS     = 20;
	localparam int CLK_PERIOD      = 100;
	localparam int RESET_CYCLES    = 3;
	localparam logic [31:0] RAND_SEED = 32'he603b388;
	// every beat may take two cycles with the random gaps, plus slack for reset and drain
	localparam int WATCHDOG_CYCLES = (NUM_FRAMES * IN_PIXELS + FLUSH_BEATS) * 2 + 50;

	logic   clk = 1'b0;
	logic   reset;
	logic   i_valid;
	pixel_t i_data;
	logic   o_valid;
	logic   o_done;
	pixel_t o_data;

	// raw words from the data file
	logic [23:0] testdata [0:TOTAL_WORDS-1];
	pixel_t      in_pixels [IN_PIXELS];
	pixel_t      exp_pixels [OUT_PIXELS];

	// monitor state
	int     out_idx = 0;
	int     frames_checked = 0;
	logic   reset_prev = 1'b0;
	logic   last_i_valid = 1'b0;
	pixel_t expected_pix;
	int     seed_value;
	logic   file_ok;

	conv_filter_top #(
		.img_width  (IMG_W),
		.img_height (IMG_H)
	) UUT (
		.clk     (clk),
		.reset   (reset),
		.i_valid (i_valid),
		.i_data  (i_data),
		.o_valid (o_valid),
		.o_done  (o_done),
		.o_data  (o_data)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic abort_run(input string reason);
		$display("*** FAILED ***");
		$fatal(1, "%s", reason);
	endtask

	// offer one pixel, idle cycles come first at random
	// roughly one cycle in four stays idle
	task automatic drive_beat(input pixel_t pix);
		logic sent;
		sent = 1'b0;
		while (!sent) begin
			@(negedge clk);
			if (($urandom % 4) == 0) begin
				i_valid = 1'b0;
				i_data  = '0;
			end else begin
				i_valid = 1'b1;
				i_data  = pix;
				sent    = 1'b1;
			end
		end
	endtask

	initial begin
		// input is live during reset, none of it may be taken as a beat
		i_valid = 1'b1;
		i_data  = '1;
		reset   = 1'b1;
		seed_value = $urandom(RAND_SEED);

		$readmemh("conv_filter_testdata.txt", testdata);
		file_ok = 1'b1;
		for (int i = 0; i < TOTAL_WORDS; i++) begin
			if ($isunknown(testdata[i])) begin
				file_ok = 1'b0;
			end
		end
		assert (file_ok)
		else begin
			abort_run("the test data file is missing or too short");
		end
		// first block is the padded frame, the rest is the expected image
		for (int i = 0; i < IN_PIXELS; i++) begin
			in_pixels[i] = testdata[i];
		end
		for (int i = 0; i < OUT_PIXELS; i++) begin
			exp_pixels[i] = testdata[IN_PIXELS + i];
		end

		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset   = 1'b0;
		i_valid = 1'b0;
		i_data  = '0;
		// a few idle cycles so the monitor sees quiet outputs before any beat
		repeat (3) @(negedge clk);

		// frames go back to back, the tracker must wrap on its own
		for (int f = 0; f < NUM_FRAMES; f++) begin
			for (int p = 0; p < IN_PIXELS; p++) begin
				drive_beat(in_pixels[p]);
			end
		end
		// zero beats push the last results out of the pipeline
		for (int p = 0; p < FLUSH_BEATS; p++) begin
			drive_beat('0);
		end
		@(negedge clk);
		i_valid = 1'b0;
		i_data  = '0;

		wait (frames_checked == NUM_FRAMES);
		repeat (2) @(posedge clk);
		$display("*** PASSED ***");
		$finish;
	end

	// output monitor, strobes are registered so the rising edge sees settled values
	always @(posedge clk) begin
		if (reset_prev) begin
			// reset was applied on the previous edge
			assert (o_valid === 1'b0 && o_done === 1'b0)
			else begin
				$display("[ERROR] %0t: strobes high after reset, valid=%b done=%b",
					$time, o_valid, o_done);
				abort_run("output strobes not cleared by reset");
			end
		end else if (!reset) begin
			// beat_valid follows i_valid one cycle late
			assert (!o_valid || last_i_valid)
			else begin
				$display("[ERROR] %0t: o_valid high without an accepted beat", $time);
				abort_run("output valid outside an accepted beat");
			end
			assert (!o_done || o_valid)
			else begin
				$display("[ERROR] %0t: o_done high while o_valid is low", $time);
				abort_run("frame end flag without a valid pixel");
			end
			if (o_valid === 1'b1) begin
				assert (frames_checked < NUM_FRAMES)
				else begin
					$display("[ERROR] %0t: extra pixel %06h after the last frame",
						$time, o_data);
					abort_run("more output pixels than expected");
				end
				expected_pix = exp_pixels[out_idx];
				assert (o_data === expected_pix)
				else begin
					$display("[ERROR] %0t: frame %0d pixel %0d expected %06h got %06h",
						$time, frames_checked, out_idx, expected_pix, o_data);
					abort_run("filtered pixel mismatch");
				end
				// done belongs on the last interior pixel only
				assert (o_done === (out_idx == OUT_PIXELS - 1))
				else begin
					$display("[ERROR] %0t: frame %0d pixel %0d o_done expected %b got %b",
						$time, frames_checked, out_idx, (out_idx == OUT_PIXELS - 1), o_done);
					abort_run("frame end flag on the wrong pixel");
				end
				if (out_idx == OUT_PIXELS - 1) begin
					out_idx = 0;
					frames_checked++;
				end else begin
					out_idx++;
				end
			end
		end
		reset_prev   = reset;
		last_i_valid = i_valid;
	end

	// watchdog
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the filtered frames never completed.",
			WATCHDOG_CYCLES);
		abort_run("timeout while waiting for output pixels");
	end

endmodule

//--- conv_filter_testdata.txt
// words 0 to 79 hold the padded 10 by 8 input frame in raster order as rrggbb
// words 80 to 127 hold the expected 8 by 6 filtered image in raster order as rrggbb
000000 000000 000000 000000 000000 000000 000000 000000 000000 000000
000000 640014 641E14 643C14 645A14 647814 649614 64B414 64D214 000000
000000 640028 641E28 643C28 645A28 647828 649628 64B428 64D228 000000
000000 64003C 641E3C 643C3C 645A3C 64783C 64963C 64B43C 64D23C 000000
000000 640050 641E50 643C50 645A50 647850 649650 64B450 64D250 000000
000000 640064 641E64 643C64 645A64 647864 649664 64B464 64D264 000000
000000 640078 641E78 643C78 645A78 647878 649678 64B478 64D278 000000
000000 000000 000000 000000 000000 000000 000000 000000 000000 000000
// expected image
FF0028 C83C14 C87814 C8B414 C8F014 C8FF14 C8FF14 FFFF28
C80050 641E28 643C28 645A28 647828 649628 64B428 C8FF50
C80078 641E3C 643C3C 645A3C 64783C 64963C 64B43C C8FF78
C800A0 641E50 643C50 645A50 647850 649650 64B450 C8FFA0
C800C8 641E64 643C64 645A64 647864 649664 64B464 C8FFC8
FF00FF C83CFF C878FF C8B4FF C8F0FF C8FFFF C8FFFF FFFFFF

//--- verilog.f
conv_filter_pkg.sv
row_delay_line.sv
frame_position_tracker.sv
channel_convolver.sv
result_clamp.sv
conv_filter_top.sv
conv_filter_assertions.sv
conv_filter_tb.sv

//--- Bender.yml
package:
  name: conv_filter

sources:
  - conv_filter_pkg.sv
  - row_delay_line.sv
  - frame_position_tracker.sv
  - channel_convolver.sv
  - result_clamp.sv
  - conv_filter_top.sv
  - target: test
    files:
      - conv_filter_assertions.sv
      - conv_filter_tb.sv
